//--- verilog/matmul_pkg.sv
package matmul_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  // Element width
  localparam int DWIDTH = 16;
  // Array dimension in rows and columns
  localparam int N = 4;
  // Operand memory address width
  localparam int AWIDTH = 7;
  // Words per operand memory; the last one is the park address
  localparam int MEM_SIZE = 128;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic signed [DWIDTH-1:0] data_t;
  typedef logic [AWIDTH-1:0] addr_t;
  typedef logic [7:0] count_t;

  // Element i is row i (A side) or column i (B side)
  typedef data_t [N-1:0] lane_t;
  // Accumulator matrix with lane i as result row i
  typedef lane_t [N-1:0] grid_t;

  // Sequencer strobes
  typedef struct packed {
    logic         clear;
    logic [N-1:0] latch;
  } seq_ctrl_t;

  // One result beat where element r belongs to row r
  typedef struct packed {
    logic [N-1:0] valid;
    lane_t        data;
  } c_row_t;

endpackage

//--- verilog/matmul_sequencer.sv
`timescale 1ns/10ps

module matmul_sequencer #(
  parameter int k_len = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start_mat_mul,
  output matmul_pkg::addr_t     a_addr,
  output matmul_pkg::addr_t     b_addr,
  output matmul_pkg::seq_ctrl_t ctrl,
  output logic                  done_mat_mul
);

  localparam matmul_pkg::addr_t PARK = matmul_pkg::addr_t'(matmul_pkg::MEM_SIZE - 1);

  // Last feed column enters PE[0][0] at count k_len+1; the far corner
  // settles N+N-2 cycles later and the last row drains N beats after that
  localparam matmul_pkg::count_t DONE_AT =
    matmul_pkg::count_t'(k_len + 2 * matmul_pkg::N + 4);

  matmul_pkg::count_t count;
  matmul_pkg::addr_t  addr_q;

  //////////////////////////////
  // Cycle counter and done
  //////////////////////////////

  // Count freezes at DONE_AT so done stays up until start drops
  always_ff @(posedge clk) begin
    if (reset || !start_mat_mul) begin
      count        <= '0;
      done_mat_mul <= 1'b0;
    end else if (count == DONE_AT) begin
      done_mat_mul <= 1'b1;
    end else begin
      count <= count + 1'b1;
    end
  end

  //////////////////////////////
  // Address generation
  //////////////////////////////

  // A column k and B row k share address k
  always_ff @(posedge clk) begin
    if (reset || !start_mat_mul) begin
      addr_q <= PARK;
    end else if (count < matmul_pkg::count_t'(k_len)) begin
      addr_q <= matmul_pkg::addr_t'(count);
    end else begin
      addr_q <= PARK;
    end
  end

  // Park at once when start drops
  assign a_addr = start_mat_mul ? addr_q : PARK;
  assign b_addr = start_mat_mul ? addr_q : PARK;

  //////////////////////////////
  // Control strobes
  //////////////////////////////

  always_comb begin
    // Hold the mesh empty while idle and for the first counted cycle
    ctrl.clear = !start_mat_mul || (count == '0);
    // Row r is final one cycle after its last PE takes the last product
    for (int r = 0; r < matmul_pkg::N; r++) begin
      ctrl.latch[r] = (count == matmul_pkg::count_t'(k_len + matmul_pkg::N + r + 1));
    end
  end

endmodule

//--- verilog/operand_skew.sv
`timescale 1ns/10ps

module operand_skew (
  input  logic                  clk,
  input  logic                  reset,
  input  matmul_pkg::seq_ctrl_t ctrl,
  input  matmul_pkg::lane_t     a_data,
  input  matmul_pkg::lane_t     b_data,
  output matmul_pkg::lane_t     a_skew,
  output matmul_pkg::lane_t     b_skew
);

  // Operand 0 is A, operand 1 is B
  matmul_pkg::lane_t lane_in [2];
  matmul_pkg::data_t tap [2][matmul_pkg::N];

  assign lane_in[0] = a_data;
  assign lane_in[1] = b_data;

  //////////////////////////////
  // Triangular delay lines
  //////////////////////////////

  for (genvar op = 0; op < 2; op++) begin : g_op
    for (genvar i = 0; i < matmul_pkg::N; i++) begin : g_lane
      if (i == 0) begin : g_direct
        assign tap[op][0] = lane_in[op][0];
      end else begin : g_delay
        // i stages for lane i
        matmul_pkg::data_t pipe [i];

        always_ff @(posedge clk) begin
          if (reset || ctrl.clear) begin
            for (int s = 0; s < i; s++) begin
              pipe[s] <= '0;
            end
          end else begin
            pipe[0] <= lane_in[op][i];
            for (int s = 1; s < i; s++) begin
              pipe[s] <= pipe[s-1];
            end
          end
        end

        assign tap[op][i] = pipe[i-1];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < matmul_pkg::N; i++) begin
      a_skew[i] = tap[0][i];
      b_skew[i] = tap[1][i];
    end
  end

endmodule

//--- verilog/processing_element.sv
`timescale 1ns/10ps

module processing_element (
  input  logic              clk,
  input  logic              reset,
  input  logic              clear,
  input  matmul_pkg::data_t in_a,
  input  matmul_pkg::data_t in_b,
  output matmul_pkg::data_t out_a,
  output matmul_pkg::data_t out_b,
  output matmul_pkg::data_t acc
);

  //////////////////////////////
  // Systolic forwarding
  //////////////////////////////

  // A moves right, B moves down, one cycle per hop
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      out_a <= '0;
      out_b <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
    end
  end

  //////////////////////////////
  // MAC
  //////////////////////////////

  // Product and sum wrap to DWIDTH bits
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      acc <= '0;
    end else begin
      acc <= acc + in_a * in_b;
    end
  end

endmodule

//--- verilog/pe_array.sv
`timescale 1ns/10ps

module pe_array (
  input  logic                  clk,
  input  logic                  reset,
  input  matmul_pkg::seq_ctrl_t ctrl,
  input  matmul_pkg::lane_t     a_skew,
  input  matmul_pkg::lane_t     b_skew,
  output matmul_pkg::grid_t     acc
);

  // a_h[i][j] feeds PE[i][j] from the left, column N is the right edge
  matmul_pkg::data_t a_h [matmul_pkg::N][matmul_pkg::N+1];
  // b_v[i][j] feeds PE[i][j] from above, row N is the bottom edge
  matmul_pkg::data_t b_v [matmul_pkg::N+1][matmul_pkg::N];

  //////////////////////////////
  // Mesh boundary
  //////////////////////////////

  for (genvar e = 0; e < matmul_pkg::N; e++) begin : g_edge
    // A row e enters on the left, B column e on top
    assign a_h[e][0] = a_skew[e];
    assign b_v[0][e] = b_skew[e];
  end

  //////////////////////////////
  // 4x4 grid
  //////////////////////////////

  for (genvar i = 0; i < matmul_pkg::N; i++) begin : g_row
    for (genvar j = 0; j < matmul_pkg::N; j++) begin : g_col
      processing_element u_pe (
        .clk   (clk),
        .reset (reset),
        .clear (ctrl.clear),
        .in_a  (a_h[i][j]),
        .in_b  (b_v[i][j]),
        .out_a (a_h[i][j+1]),
        .out_b (b_v[i+1][j]),
        .acc   (acc[i][j])
      );
    end
  end

endmodule

//--- verilog/result_shifter.sv
`timescale 1ns/10ps

module result_shifter (
  input  logic                  clk,
  input  logic                  reset,
  input  matmul_pkg::seq_ctrl_t ctrl,
  input  matmul_pkg::grid_t     acc,
  output matmul_pkg::c_row_t    c_out
);

  localparam int CW = $clog2(matmul_pkg::N + 1);

  // Row shift registers with element 0 as the beat on the output
  matmul_pkg::lane_t shift_q [matmul_pkg::N];
  // Beats left per row
  logic [CW-1:0] beats_q [matmul_pkg::N];

  //////////////////////////////
  // Row data
  //////////////////////////////

  always_ff @(posedge clk) begin
    for (int r = 0; r < matmul_pkg::N; r++) begin
      if (ctrl.latch[r]) begin
        shift_q[r] <= acc[r];
      end else begin
        // Column 0 leaves first while zeros fill from the top
        shift_q[r] <= {matmul_pkg::data_t'(0), shift_q[r][matmul_pkg::N-1:1]};
      end
    end
  end

  //////////////////////////////
  // Beat counters
  //////////////////////////////

  always_ff @(posedge clk) begin
    for (int r = 0; r < matmul_pkg::N; r++) begin
      if (reset) begin
        beats_q[r] <= '0;
      end else if (ctrl.latch[r]) begin
        beats_q[r] <= CW'(matmul_pkg::N);
      end else if (beats_q[r] != '0) begin
        beats_q[r] <= beats_q[r] - 1'b1;
      end
    end
  end

  always_comb begin
    for (int r = 0; r < matmul_pkg::N; r++) begin
      c_out.valid[r] = (beats_q[r] != '0);
      c_out.data[r]  = shift_q[r][0];
    end
  end

endmodule

//--- verilog/systolic_matmul.sv
`timescale 1ns/10ps

module systolic_matmul #(
  // Inner dimension, 1 to 32
  parameter int k_len = 4
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               start_mat_mul,
  input  matmul_pkg::lane_t  a_data,
  input  matmul_pkg::lane_t  b_data,
  output matmul_pkg::addr_t  a_addr,
  output matmul_pkg::addr_t  b_addr,
  output matmul_pkg::c_row_t c_out,
  output logic               done_mat_mul
);

  matmul_pkg::seq_ctrl_t ctrl;
  matmul_pkg::lane_t     a_skew;
  matmul_pkg::lane_t     b_skew;
  matmul_pkg::grid_t     acc;

  //////////////////////////////
  // Decode
  //////////////////////////////

  matmul_sequencer #(
    .k_len (k_len)
  ) u_sequencer (
    .clk           (clk),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .a_addr        (a_addr),
    .b_addr        (b_addr),
    .ctrl          (ctrl),
    .done_mat_mul  (done_mat_mul)
  );

  //////////////////////////////
  // Execute
  //////////////////////////////

  operand_skew u_skew (
    .clk    (clk),
    .reset  (reset),
    .ctrl   (ctrl),
    .a_data (a_data),
    .b_data (b_data),
    .a_skew (a_skew),
    .b_skew (b_skew)
  );

  pe_array u_array (
    .clk    (clk),
    .reset  (reset),
    .ctrl   (ctrl),
    .a_skew (a_skew),
    .b_skew (b_skew),
    .acc    (acc)
  );

  //////////////////////////////
  // Result
  //////////////////////////////

  result_shifter u_shifter (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl),
    .acc   (acc),
    .c_out (c_out)
  );

endmodule

//--- bench/systolic_matmul_properties.sv
`timescale 1ns/10ps

module systolic_matmul_properties (
  input logic                clk,
  input logic                reset,
  input logic                start_mat_mul,
  input logic                done_mat_mul,
  input matmul_pkg::addr_t   a_addr,
  input matmul_pkg::addr_t   b_addr,
  input matmul_pkg::c_row_t  c_out
);

  localparam matmul_pkg::addr_t PARK = matmul_pkg::addr_t'(matmul_pkg::MEM_SIZE - 1);
  localparam int RW = $clog2(matmul_pkg::N + 1);

  // Count of failed assertions
  int assert_fails = 0;

  // Consecutive cycles each valid bit has been high
  logic [RW-1:0] high_run [matmul_pkg::N];

  always_ff @(posedge clk) begin
    for (int r = 0; r < matmul_pkg::N; r++) begin
      if (reset || !c_out.valid[r]) begin
        high_run[r] <= '0;
      end else begin
        high_run[r] <= high_run[r] + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  a_park: assert property (@(posedge clk) disable iff (reset)
    !start_mat_mul |-> (a_addr == PARK && b_addr == PARK))
    else begin
      $error("operand addresses left the park address while start_mat_mul is low");
      assert_fails++;
    end

  a_done_hold: assert property (@(posedge clk) disable iff (reset)
    (done_mat_mul && start_mat_mul) |=> done_mat_mul)
    else begin
      $error("done_mat_mul fell while start_mat_mul was still high");
      assert_fails++;
    end

  //////////////////////////////
  // Result beats
  //////////////////////////////

  for (genvar r = 0; r < matmul_pkg::N; r++) begin : g_row
    a_valid_max: assert property (@(posedge clk) disable iff (reset)
      c_out.valid[r] |-> high_run[r] < RW'(matmul_pkg::N))
      else begin
        $error("c_out.valid[%0d] stayed high longer than %0d cycles", r, matmul_pkg::N);
        assert_fails++;
      end

    a_valid_min: assert property (@(posedge clk) disable iff (reset)
      (!c_out.valid[r] && high_run[r] != '0) |-> high_run[r] == RW'(matmul_pkg::N))
      else begin
        $error("c_out.valid[%0d] fell before %0d cycles", r, matmul_pkg::N);
        assert_fails++;
      end
  end

endmodule

//--- bench/tb_systolic_matmul.sv
`timescale 1ns/10ps

module tb_systolic_matmul;

  localparam int K_LEN = 4;
  localparam int N = matmul_pkg::N;
  localparam int SEED = 89726;
  localparam int RESET_CYCLES = 8;
  localparam int HOLD_CYCLES = 3;
  localparam int GAP_CYCLES = 4;
  localparam int BACK_TO_BACK = 3;
  localparam int DONE_TIMEOUT = 200;
  localparam matmul_pkg::addr_t PARK = matmul_pkg::addr_t'(matmul_pkg::MEM_SIZE - 1);

  logic               clk;
  logic               reset;
  logic               start_mat_mul;
  matmul_pkg::lane_t  a_data = '0;
  matmul_pkg::lane_t  b_data = '0;
  matmul_pkg::addr_t  a_addr;
  matmul_pkg::addr_t  b_addr;
  matmul_pkg::c_row_t c_out;
  logic               done_mat_mul;

  // Operands and expected result with C[r][j] in exp_c[r][j]
  matmul_pkg::data_t mat_a [N][K_LEN];
  matmul_pkg::data_t mat_b [K_LEN][N];
  matmul_pkg::data_t exp_c [N][N];

  // Addresses captured by the memory models
  matmul_pkg::addr_t a_rd_addr = PARK;
  matmul_pkg::addr_t b_rd_addr = PARK;

  int run_epoch = 0;
  int seen_epoch = 0;
  int beat_cnt [N];
  int mon_errors = 0;
  int main_errors = 0;
  int test_count = 0;
  int unsigned seed_value;

  systolic_matmul #(
    .k_len (K_LEN)
  ) u_dut (
    .clk           (clk),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .a_data        (a_data),
    .b_data        (b_data),
    .a_addr        (a_addr),
    .b_addr        (b_addr),
    .c_out         (c_out),
    .done_mat_mul  (done_mat_mul)
  );

  bind systolic_matmul systolic_matmul_properties u_properties (
    .clk           (clk),
    .reset         (reset),
    .start_mat_mul (start_mat_mul),
    .done_mat_mul  (done_mat_mul),
    .a_addr        (a_addr),
    .b_addr        (b_addr),
    .c_out         (c_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  // Operand memories
  //////////////////////////////

  function automatic matmul_pkg::lane_t a_column(input matmul_pkg::addr_t addr);
    matmul_pkg::lane_t lane;
    int k;
    lane = '0;
    k = int'(addr);
    if (k < K_LEN) begin
      for (int i = 0; i < N; i++) begin
        lane[i] = mat_a[i][k];
      end
    end
    return lane;
  endfunction

  function automatic matmul_pkg::lane_t b_row(input matmul_pkg::addr_t addr);
    matmul_pkg::lane_t lane;
    int k;
    lane = '0;
    k = int'(addr);
    if (k < K_LEN) begin
      for (int j = 0; j < N; j++) begin
        lane[j] = mat_b[k][j];
      end
    end
    return lane;
  endfunction

  // Address taken on the rising edge and data driven for the next rising edge
  always @(posedge clk) begin
    a_rd_addr <= a_addr;
    b_rd_addr <= b_addr;
  end

  always @(negedge clk) begin
    a_data <= a_column(a_rd_addr);
    b_data <= b_row(b_rd_addr);
  end

  //////////////////////////////
  // Reference and checks
  //////////////////////////////

  function automatic matmul_pkg::data_t ref_element(input int i, input int j);
    longint sum;
    sum = 0;
    for (int k = 0; k < K_LEN; k++) begin
      sum += longint'(mat_a[i][k]) * longint'(mat_b[k][j]);
    end
    return matmul_pkg::data_t'(sum);
  endfunction

  task automatic compare_data(input string name, input matmul_pkg::data_t got,
                              input matmul_pkg::data_t expected, inout int errors);
    if (got !== expected) begin
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, got);
      errors++;
    end
  endtask

  task automatic compare_done(input string name, input logic got, input logic expected,
                              inout int errors);
    if (got !== expected) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, expected, got);
      errors++;
    end
  endtask

  task automatic compare_valid(input string name, input logic [N-1:0] got,
                               input logic [N-1:0] expected, inout int errors);
    if (got !== expected) begin
      $display("** Error at %0t: %s expected %b, got %b", $time, name, expected, got);
      errors++;
    end
  endtask

  task automatic compare_addr(input string name, input matmul_pkg::addr_t got,
                              input matmul_pkg::addr_t expected, inout int errors);
    if (got !== expected) begin
      $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, got);
      errors++;
    end
  endtask

  function automatic int total_errors();
    return main_errors + mon_errors + u_dut.u_properties.assert_fails;
  endfunction

  // Each row's beats checked in column order
  always @(negedge clk) begin
    if (seen_epoch != run_epoch) begin
      seen_epoch = run_epoch;
      for (int r = 0; r < N; r++) begin
        beat_cnt[r] = 0;
      end
    end
    for (int r = 0; r < N; r++) begin
      if (c_out.valid[r] === 1'b1) begin
        if (beat_cnt[r] < N) begin
          compare_data($sformatf("c_out.data[%0d] beat %0d", r, beat_cnt[r]),
                       c_out.data[r], exp_c[r][beat_cnt[r]], mon_errors);
        end else begin
          $display("Row %0d gave more than %0d valid beats in one run", r, N);
          mon_errors++;
        end
        beat_cnt[r]++;
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic randomize_operands();
    for (int i = 0; i < N; i++) begin
      for (int k = 0; k < K_LEN; k++) begin
        mat_a[i][k] = matmul_pkg::data_t'($urandom);
        mat_b[k][i] = matmul_pkg::data_t'($urandom);
      end
    end
  endtask

  task automatic expect_reference();
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        exp_c[i][j] = ref_element(i, j);
      end
    end
  endtask

  // One full run, then drop start and check the idle state
  task automatic run_matmul();
    int cycles;
    run_epoch++;
    @(negedge clk);
    start_mat_mul = 1'b1;
    cycles = 0;
    while (done_mat_mul !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > DONE_TIMEOUT) begin
        $display("Timeout: done_mat_mul stayed low for %0d cycles", DONE_TIMEOUT);
        $display("Simulation failed");
        $finish;
      end
    end
    for (int r = 0; r < N; r++) begin
      if (beat_cnt[r] != N) begin
        $display("Row %0d gave %0d valid beats before done_mat_mul rose, expected %0d",
                 r, beat_cnt[r], N);
        main_errors++;
      end
    end
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      compare_done("done_mat_mul", done_mat_mul, 1'b1, main_errors);
    end
    start_mat_mul = 1'b0;
    @(negedge clk);
    compare_done("done_mat_mul", done_mat_mul, 1'b0, main_errors);
    compare_valid("c_out.valid", c_out.valid, '0, main_errors);
    compare_addr("a_addr", a_addr, PARK, main_errors);
    compare_addr("b_addr", b_addr, PARK, main_errors);
  endtask

  task automatic finish_test(input string label, input int errors_before);
    test_count++;
    $display("Test %0d %s finished with %0d errors", test_count, label,
             total_errors() - errors_before);
  endtask

  initial begin
    int errors_before;
    seed_value = $urandom(SEED);
    reset = 1'b1;
    start_mat_mul = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;

    // Idle after reset
    errors_before = total_errors();
    repeat (2) begin
      @(negedge clk);
      compare_done("done_mat_mul", done_mat_mul, 1'b0, main_errors);
      compare_valid("c_out.valid", c_out.valid, '0, main_errors);
      compare_addr("a_addr", a_addr, PARK, main_errors);
      compare_addr("b_addr", b_addr, PARK, main_errors);
    end
    finish_test("idle after reset", errors_before);

    // Identity A gives back B row by row
    errors_before = total_errors();
    randomize_operands();
    for (int i = 0; i < N; i++) begin
      for (int k = 0; k < K_LEN; k++) begin
        mat_a[i][k] = (i == k) ? matmul_pkg::data_t'(1) : matmul_pkg::data_t'(0);
      end
    end
    for (int r = 0; r < N; r++) begin
      for (int j = 0; j < N; j++) begin
        exp_c[r][j] = mat_b[r][j];
      end
    end
    run_matmul();
    finish_test("identity A", errors_before);

    // Full signed range with rows 0 and 1 forced to wrap
    errors_before = total_errors();
    randomize_operands();
    for (int k = 0; k < K_LEN; k++) begin
      mat_a[0][k] = 16'sh8000;
      mat_b[k][0] = 16'sh8000;
      mat_a[1][k] = 16'sh7fff;
      mat_b[k][1] = 16'sh7fff;
    end
    expect_reference();
    run_matmul();
    finish_test("full range with wrap", errors_before);

    for (int n = 0; n < BACK_TO_BACK; n++) begin
      errors_before = total_errors();
      repeat (GAP_CYCLES) @(negedge clk);
      randomize_operands();
      expect_reference();
      run_matmul();
      finish_test($sformatf("back-to-back run %0d", n), errors_before);
    end

    $display("Tests: %0d, errors: %0d", test_count, total_errors());
    if (total_errors() == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- list.f
verilog/matmul_pkg.sv
verilog/matmul_sequencer.sv
verilog/operand_skew.sv
verilog/processing_element.sv
verilog/pe_array.sv
verilog/result_shifter.sv
verilog/systolic_matmul.sv
bench/systolic_matmul_properties.sv
bench/tb_systolic_matmul.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_systolic_matmul
FILELIST = list.f
BUILD    = obj_dir
PASS_MSG = Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and look for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
